//--- hdl/mc_cfg.svh
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

// Device ID carried in every flit header
`define MC_DID_W 4

// Scratch memory word address
`define MC_ADDR_W 4

`define MC_DATA_W 32

// Must cover the full address range
`define MC_MEM_WORDS 16

// Default number of flits per link buffer
`define MC_FIFO_DEPTH 2

`endif

//--- hdl/mc_pkg.sv
`default_nettype none

`include "mc_cfg.svh"

package mc_pkg;

  typedef enum logic [1:0] {
    MC_OP_WRITE = 2'd0,
    MC_OP_READ  = 2'd1,
    MC_OP_FADD  = 2'd2
  } mc_op_e;

  typedef enum logic [1:0] {
    MC_ST_OK   = 2'd0,
    MC_ST_NACK = 2'd1
  } mc_status_e;

  typedef enum logic {
    MC_MSG_CMD  = 1'b0,
    MC_MSG_RESP = 1'b1
  } mc_msg_e;

  // Opcode sits in the top bits and data in the low bits of both views
  typedef struct packed {
    mc_op_e                 op;
    logic [`MC_ADDR_W-1:0]  addr;
    logic [`MC_DATA_W-1:0]  data;
  } mc_cmd_s;

  typedef struct packed {
    mc_op_e                 op;
    mc_status_e             status;
    logic [1:0]             pad;
    logic [`MC_DATA_W-1:0]  data;
  } mc_resp_s;

  // Decoded by msg type
  typedef union packed {
    mc_cmd_s   cmd;
    mc_resp_s  resp;
  } mc_payload_u;

  typedef struct packed {
    logic [`MC_DID_W-1:0]  did;
    logic [`MC_DID_W-1:0]  sid;
    mc_msg_e               msg;
    mc_payload_u           payload;
  } mc_flit_s;

  // Forward half of a ready-and link, ready runs separately
  typedef struct packed {
    logic      v;
    mc_flit_s  flit;
  } mc_link_s;

endpackage

`default_nettype wire

//--- hdl/mc_link_fifo.sv
`default_nettype none

`include "mc_cfg.svh"

module mc_link_fifo
 #(parameter int depth_p = `MC_FIFO_DEPTH)
  (input wire logic                 core_clk_i
   , input wire logic               rst_n_i

   , input wire mc_pkg::mc_link_s   link_i
   , output logic                   ready_o

   , output mc_pkg::mc_link_s       link_o
   , input wire logic               ready_i
   );

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  mc_pkg::mc_flit_s mem_r [depth_p];

  logic [ptr_w_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic push, pop, full;

  assign full = (count_r == cnt_w_lp'(depth_p));

  // A full buffer still takes a flit when one leaves in the same cycle
  assign ready_o = ~full | ready_i;
  assign push    = link_i.v & ready_o;
  assign pop     = link_o.v & ready_i;

  assign link_o = '{v: (count_r != '0), flit: mem_r[rd_ptr_r]};

  always_ff @(posedge core_clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= link_i.flit;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/mc_io_complex.sv
`default_nettype none

`include "mc_cfg.svh"

module mc_io_complex
  (input wire logic                   core_clk_i
   , input wire logic                 rst_n_i

   , input wire logic [`MC_DID_W-1:0] my_did_i

   , input wire mc_pkg::mc_link_s     host_cmd_link_i
   , output logic                     host_cmd_ready_o

   , output mc_pkg::mc_link_s         host_resp_link_o
   , input wire logic                 host_resp_ready_i

   , output mc_pkg::mc_link_s         mem_cmd_link_o
   , input wire logic                 mem_cmd_ready_i

   , input wire mc_pkg::mc_link_s     mem_resp_link_i
   , output logic                     mem_resp_ready_o
   );

  mc_pkg::mc_flit_s host_flit;
  mc_pkg::mc_flit_s nack_flit;
  mc_pkg::mc_flit_s nack_flit_r;
  logic             nack_v_r;
  logic             id_match;
  logic             nack_push;
  logic             nack_pop;

  assign host_flit = host_cmd_link_i.flit;
  assign id_match  = (host_flit.did == my_did_i);

  // Everything stalls while a NACK waits, so the host sees one ready
  assign host_cmd_ready_o = ~nack_v_r & (id_match ? mem_cmd_ready_i : 1'b1);

  assign mem_cmd_link_o = '{v: host_cmd_link_i.v & id_match & ~nack_v_r,
                            flit: host_flit};

  assign nack_push = host_cmd_link_i.v & host_cmd_ready_o & ~id_match;

  // Reply goes back to the sender with the opcode echoed
  always_comb begin
    nack_flit                     = '0;
    nack_flit.did                 = host_flit.sid;
    nack_flit.sid                 = my_did_i;
    nack_flit.msg                 = mc_pkg::MC_MSG_RESP;
    nack_flit.payload.resp.op     = host_flit.payload.cmd.op;
    nack_flit.payload.resp.status = mc_pkg::MC_ST_NACK;
    nack_flit.payload.resp.pad    = '0;
    nack_flit.payload.resp.data   = '0;
  end

  // Memory responses win, the NACK waits for a free cycle
  assign host_resp_link_o = '{v: mem_resp_link_i.v | nack_v_r,
                              flit: mem_resp_link_i.v ? mem_resp_link_i.flit : nack_flit_r};

  assign mem_resp_ready_o = host_resp_ready_i;

  assign nack_pop = nack_v_r & ~mem_resp_link_i.v & host_resp_ready_i;

  always_ff @(posedge core_clk_i) begin
    if (nack_push) begin
      nack_flit_r <= nack_flit;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nack_v_r <= 1'b0;
    end else if (nack_push) begin
      nack_v_r <= 1'b1;
    end else if (nack_pop) begin
      nack_v_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mc_mem_complex.sv
`default_nettype none

`include "mc_cfg.svh"

module mc_mem_complex
  (input wire logic                   core_clk_i
   , input wire logic                 rst_n_i

   , input wire logic [`MC_DID_W-1:0] my_did_i

   , input wire mc_pkg::mc_link_s     cmd_link_i
   , output logic                     cmd_ready_o

   , output mc_pkg::mc_link_s         resp_link_o
   , input wire logic                 resp_ready_i
   );

  logic [`MC_DATA_W-1:0] mem_r [`MC_MEM_WORDS];

  mc_pkg::mc_cmd_s       cmd;
  mc_pkg::mc_flit_s      resp_flit;
  mc_pkg::mc_flit_s      resp_flit_r;
  mc_pkg::mc_status_e    status;
  logic                  resp_v_r;
  logic                  accept;
  logic                  wr_en;
  logic [`MC_DATA_W-1:0] old_word;
  logic [`MC_DATA_W-1:0] wr_data;
  logic [`MC_DATA_W-1:0] rd_data;

  // Drain and accept may share a cycle
  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign accept      = cmd_link_i.v & cmd_ready_o;

  assign cmd      = cmd_link_i.flit.payload.cmd;
  assign old_word = mem_r[cmd.addr];

  always_comb begin
    wr_en   = 1'b0;
    wr_data = old_word;
    rd_data = old_word;
    status  = mc_pkg::MC_ST_OK;
    case (cmd.op)
      mc_pkg::MC_OP_WRITE: begin
        wr_en   = 1'b1;
        wr_data = cmd.data;
        rd_data = cmd.data;
      end
      mc_pkg::MC_OP_READ: begin
        wr_en = 1'b0;
      end
      // Old value returned, sum wraps at 32 bits
      mc_pkg::MC_OP_FADD: begin
        wr_en   = 1'b1;
        wr_data = old_word + cmd.data;
      end
      default: begin
        status  = mc_pkg::MC_ST_NACK;
        rd_data = '0;
      end
    endcase
  end

  always_comb begin
    resp_flit                     = '0;
    resp_flit.did                 = cmd_link_i.flit.sid;
    resp_flit.sid                 = my_did_i;
    resp_flit.msg                 = mc_pkg::MC_MSG_RESP;
    resp_flit.payload.resp.op     = cmd.op;
    resp_flit.payload.resp.status = status;
    resp_flit.payload.resp.pad    = '0;
    resp_flit.payload.resp.data   = rd_data;
  end

  assign resp_link_o = '{v: resp_v_r, flit: resp_flit_r};

  // Scratch contents start at zero
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MC_MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (accept & wr_en) begin
      mem_r[cmd.addr] <= wr_data;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (accept) begin
      resp_flit_r <= resp_flit;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_r <= 1'b0;
    end else if (accept) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mc_multicore.sv
`default_nettype none

`include "mc_cfg.svh"

module mc_multicore
  (input wire logic                   core_clk_i
   , input wire logic                 rst_n_i

   , input wire logic [`MC_DID_W-1:0] my_did_i

   , input wire mc_pkg::mc_link_s     io_cmd_link_i
   , output logic                     io_cmd_ready_o

   , output mc_pkg::mc_link_s         io_resp_link_o
   , input wire logic                 io_resp_ready_i
   );

  // lo is driven by a complex, li feeds one
  mc_pkg::mc_link_s cmd_link_lo, cmd_link_li;
  mc_pkg::mc_link_s resp_link_lo, resp_link_li;
  logic             cmd_ready_lo, cmd_ready_li;
  logic             resp_ready_lo, resp_ready_li;

  mc_io_complex
   ic
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_did_i(my_did_i)

     ,.host_cmd_link_i(io_cmd_link_i)
     ,.host_cmd_ready_o(io_cmd_ready_o)
     ,.host_resp_link_o(io_resp_link_o)
     ,.host_resp_ready_i(io_resp_ready_i)

     ,.mem_cmd_link_o(cmd_link_lo)
     ,.mem_cmd_ready_i(cmd_ready_li)
     ,.mem_resp_link_i(resp_link_li)
     ,.mem_resp_ready_o(resp_ready_lo)
     );

  mc_link_fifo
   #(.depth_p(`MC_FIFO_DEPTH))
   cmd_fifo
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.link_i(cmd_link_lo)
     ,.ready_o(cmd_ready_li)
     ,.link_o(cmd_link_li)
     ,.ready_i(cmd_ready_lo)
     );

  mc_mem_complex
   mc
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_did_i(my_did_i)
     ,.cmd_link_i(cmd_link_li)
     ,.cmd_ready_o(cmd_ready_lo)
     ,.resp_link_o(resp_link_lo)
     ,.resp_ready_i(resp_ready_li)
     );

  mc_link_fifo
   #(.depth_p(`MC_FIFO_DEPTH))
   resp_fifo
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.link_i(resp_link_lo)
     ,.ready_o(resp_ready_li)
     ,.link_o(resp_link_li)
     ,.ready_i(resp_ready_lo)
     );

endmodule

`default_nettype wire

//--- tests/tb_mc_tasks.svh
`ifndef TB_MC_TASKS_SVH
`define TB_MC_TASKS_SVH

function automatic logic [`MC_DATA_W-1:0] rand_word();
  return $random(seed);
endfunction

task automatic check_flit(input string name, input mc_pkg::mc_flit_s got,
                          input mc_pkg::mc_flit_s exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic check_status(input string name, input mc_pkg::mc_status_e got,
                            input mc_pkg::mc_status_e exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// Reference model, updated in command order
task automatic predict_resp(input mc_pkg::mc_flit_s cmd_flit, output mc_pkg::mc_flit_s resp);
  mc_pkg::mc_cmd_s       cmd;
  logic [`MC_DATA_W-1:0] old_word;
  cmd = cmd_flit.payload.cmd;
  resp = '0;
  resp.did = cmd_flit.sid;
  resp.sid = my_did_lp;
  resp.msg = mc_pkg::MC_MSG_RESP;
  resp.payload.resp.op = cmd.op;
  if (cmd_flit.did != my_did_lp) begin
    resp.payload.resp.status = mc_pkg::MC_ST_NACK;
  end else begin
    old_word = ref_mem[cmd.addr];
    resp.payload.resp.status = mc_pkg::MC_ST_OK;
    resp.payload.resp.data = old_word;
    if (cmd.op == mc_pkg::MC_OP_WRITE) begin
      ref_mem[cmd.addr] = cmd.data;
      resp.payload.resp.data = cmd.data;
    end else if (cmd.op == mc_pkg::MC_OP_FADD) begin
      ref_mem[cmd.addr] = old_word + cmd.data;
    end
  end
endtask

// Holds the flit until the handshake edge, then drops valid
task automatic send_cmd(input logic [`MC_DID_W-1:0] did, input logic [`MC_DID_W-1:0] sid,
                        input mc_pkg::mc_op_e op, input logic [`MC_ADDR_W-1:0] addr,
                        input logic [`MC_DATA_W-1:0] data);
  mc_pkg::mc_link_s link;
  mc_pkg::mc_flit_s exp;
  link = '0;
  link.v = 1'b1;
  link.flit.did = did;
  link.flit.sid = sid;
  link.flit.msg = mc_pkg::MC_MSG_CMD;
  link.flit.payload.cmd.op = op;
  link.flit.payload.cmd.addr = addr;
  link.flit.payload.cmd.data = data;
  predict_resp(link.flit, exp);
  exp_q.push_back(exp);
  @(posedge core_clk);
  io_cmd_link <= link;
  @(negedge core_clk);
  while (!io_cmd_ready) begin
    @(negedge core_clk);
  end
  @(posedge core_clk);
  io_cmd_link.v <= 1'b0;
  sent_cnt++;
endtask

task automatic wait_drained();
  while (exp_q.size() != 0) begin
    @(negedge core_clk);
  end
endtask

task automatic write_read_all_words();
  for (int a = 0; a < `MC_MEM_WORDS; a++) begin
    send_cmd(my_did_lp, `MC_DID_W'(rand_word()), mc_pkg::MC_OP_WRITE, `MC_ADDR_W'(a),
             rand_word());
  end
  for (int a = 0; a < `MC_MEM_WORDS; a++) begin
    send_cmd(my_did_lp, `MC_DID_W'(rand_word()), mc_pkg::MC_OP_READ, `MC_ADDR_W'(a), '0);
  end
  wait_drained();
endtask

task automatic fetch_add_chain();
  logic [`MC_ADDR_W-1:0] addr;
  addr = `MC_ADDR_W'(rand_word());
  for (int i = 0; i < 6; i++) begin
    send_cmd(my_did_lp, `MC_DID_W'(rand_word()), mc_pkg::MC_OP_FADD, addr, rand_word());
  end
  // Accumulated sum
  send_cmd(my_did_lp, `MC_DID_W'(rand_word()), mc_pkg::MC_OP_READ, addr, '0);
  wait_drained();
endtask

task automatic nack_on_bad_did();
  send_cmd(my_did_lp ^ 4'hF, 4'h3, mc_pkg::MC_OP_WRITE, 4'h3, rand_word());
  wait_drained();
  send_cmd(my_did_lp, 4'h3, mc_pkg::MC_OP_READ, 4'h3, '0);
  wait_drained();
endtask

task automatic resp_stall_burst();
  int   base;
  logic stalled;
  base = sent_cnt;
  stalled = 1'b0;
  @(posedge core_clk);
  io_resp_ready <= 1'b0;
  fork
    begin
      for (int i = 0; i < burst_lp; i++) begin
        send_cmd(my_did_lp, `MC_DID_W'(rand_word()),
                 mc_pkg::mc_op_e'(2'(rand_word() % 3)), `MC_ADDR_W'(rand_word()),
                 rand_word());
      end
    end
    begin
      while (!stalled && (sent_cnt - base) < burst_lp) begin
        @(negedge core_clk);
        if (io_cmd_link.v && !io_cmd_ready) begin
          stalled = 1'b1;
        end
      end
      repeat (4) @(posedge core_clk);
      io_resp_ready <= 1'b1;
    end
  join
  if (!stalled) begin
    stop_run("io_cmd_ready_o never dropped while responses were blocked");
  end else begin
    wait_drained();
  end
endtask

// Each source ID reads once so the reply header is seen for all of them
task automatic reply_header_per_sid();
  for (int s = 0; s < 16; s++) begin
    send_cmd(my_did_lp, `MC_DID_W'(s), mc_pkg::MC_OP_READ, `MC_ADDR_W'(rand_word()), '0);
  end
  wait_drained();
endtask

`endif

//--- tests/tb_mc_multicore.sv
`default_nettype none

`include "mc_cfg.svh"

module tb_mc_multicore;

  localparam logic [`MC_DID_W-1:0] my_did_lp = 4'h5;
  // Commands issued by all tests together
  localparam int num_txn_lp = 67;
  localparam int burst_lp   = 10;

  logic                  core_clk = 1'b0;
  logic                  rst_n;
  logic [`MC_DID_W-1:0]  my_did;
  mc_pkg::mc_link_s      io_cmd_link;
  logic                  io_cmd_ready;
  mc_pkg::mc_link_s      io_resp_link;
  logic                  io_resp_ready;

  integer                seed = 31;
  logic [`MC_DATA_W-1:0] ref_mem [`MC_MEM_WORDS];
  mc_pkg::mc_flit_s      exp_q [$];
  mc_pkg::mc_flit_s      mon_exp;
  int                    sent_cnt = 0;
  int                    rcvd_cnt = 0;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  `include "tb_mc_tasks.svh"

  always #20 core_clk = ~core_clk;

  mc_multicore i_mc_multicore
    (.core_clk_i(core_clk)
     ,.rst_n_i(rst_n)
     ,.my_did_i(my_did)
     ,.io_cmd_link_i(io_cmd_link)
     ,.io_cmd_ready_o(io_cmd_ready)
     ,.io_resp_link_o(io_resp_link)
     ,.io_resp_ready_i(io_resp_ready)
     );

  // Response handshakes complete on the next rising edge
  always @(negedge core_clk) begin
    if (rst_n && io_resp_link.v && io_resp_ready) begin
      if (exp_q.size() == 0) begin
        stop_run("response arrived with no command outstanding");
      end else begin
        mon_exp = exp_q.pop_front();
        check_status("io_resp_link_o.flit.payload.resp.status",
                     io_resp_link.flit.payload.resp.status, mon_exp.payload.resp.status);
        check_flit("io_resp_link_o.flit", io_resp_link.flit, mon_exp);
        rcvd_cnt++;
      end
    end
  end

  initial begin
    repeat (num_txn_lp * 50) @(posedge core_clk);
    stop_run("watchdog timeout, responses missing");
  end

  initial begin
    rst_n         <= 1'b0;
    my_did        <= my_did_lp;
    io_cmd_link   <= '0;
    io_resp_ready <= 1'b1;
    for (int i = 0; i < `MC_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(posedge core_clk);
    rst_n <= 1'b1;
    @(negedge core_clk);
    check_bit("io_resp_link_o.v", io_resp_link.v, 1'b0);
    check_bit("io_cmd_ready_o", io_cmd_ready, 1'b1);

    write_read_all_words();
    fetch_add_chain();
    nack_on_bad_did();
    resp_stall_burst();
    reply_header_per_sid();

    repeat (5) @(posedge core_clk);
    if (exp_q.size() != 0 || rcvd_cnt != sent_cnt) begin
      stop_run("responses missing at end of run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- mc_multicore.f
+incdir+hdl
+incdir+tests
hdl/mc_pkg.sv
hdl/mc_link_fifo.sv
hdl/mc_io_complex.sv
hdl/mc_mem_complex.sv
hdl/mc_multicore.sv
tests/tb_mc_multicore.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mc_multicore testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

verilator --binary -j 0 --top-module tb_mc_multicore \
  --Mdir "$obj_dir" -o tb_mc_multicore -f mc_multicore.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$obj_dir/tb_mc_multicore" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -qF "*** TEST FAILED ***" "$log_file"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0
